//--- MicrorocDaq.f
hdl/DaqCtrlPkg.sv
hdl/EventPkg.sv
hdl/DaqSequencer.sv
hdl/ReadoutDeserializer.sv
hdl/EventFifo.sv
hdl/EventFramer.sv
hdl/MicrorocDaq.sv
sim/ClkGen.sv
sim/DaqChecker.sv
sim/MicrorocDaqTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module MicrorocDaqTb -f MicrorocDaq.f -o MicrorocDaqSim
	./obj_dir/MicrorocDaqSim | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/MicrorocDaqTb.sv
`timescale 1ns/1ps

module MicrorocDaqTb;

  localparam int unsigned PwrRstCycles   = 8;
  localparam int unsigned RstStartCycles = 40;
  localparam int unsigned SroCycles      = 16;
  localparam int unsigned FifoDepth      = 16;
  localparam int unsigned NumEvents      = 6;
  localparam int unsigned CycleLimit     = 2000 * NumEvents;
  localparam int unsigned NoLimit        = 32'hffff_ffff; // Host never stalls

  logic                  Clk;
  logic                  reset_n;
  logic                  start;
  logic                  startEnable;
  logic [15:0]           acqTime;
  logic                  chipSatB;
  logic                  endReadout;
  logic                  dout;
  logic                  transmitOn;
  logic                  outBusy;
  DaqCtrlPkg::asicCtrl_t asicCtrl;
  logic                  onceEnd;
  EventPkg::dataWord_t   outWord;
  logic                  outValid;
  logic                  overflow;
  int unsigned           cycleCnt = 0;
  int unsigned           seedVal;

  ClkGen clkGen (
    .Clk    (Clk),
    .reset_n(reset_n)
  );

  MicrorocDaq #(
    .PwrRstCycles  (PwrRstCycles),
    .RstStartCycles(RstStartCycles),
    .SroCycles     (SroCycles),
    .FifoDepth     (FifoDepth)
  ) dut (
    .Clk        (Clk),
    .reset_n    (reset_n),
    .start      (start),
    .startEnable(startEnable),
    .acqTime    (acqTime),
    .chipSatB   (chipSatB),
    .endReadout (endReadout),
    .dout       (dout),
    .transmitOn (transmitOn),
    .outBusy    (outBusy),
    .asicCtrl   (asicCtrl),
    .onceEnd    (onceEnd),
    .outWord    (outWord),
    .outValid   (outValid),
    .overflow   (overflow)
  );

  DaqChecker #(
    .PwrRstCycles  (PwrRstCycles),
    .RstStartCycles(RstStartCycles),
    .SroCycles     (SroCycles)
  ) chk (
    .Clk     (Clk),
    .reset_n (reset_n),
    .acqTime (acqTime),
    .chipSatB(chipSatB),
    .outBusy (outBusy),
    .asicCtrl(asicCtrl),
    .onceEnd (onceEnd),
    .outWord (outWord),
    .outValid(outValid),
    .overflow(overflow)
  );

  ////////////////////////////////////////////////////////////
  // ASIC model
  ////////////////////////////////////////////////////////////

  task automatic waitCycles(input int unsigned n);
    repeat (n) @(negedge Clk);
  endtask

  task automatic sendWord(input EventPkg::dataWord_t w);
    for (int i = 15; i >= 0; i--) begin
      @(negedge Clk);
      transmitOn = 1'b1;
      dout       = w[i]; // MSB first
    end
  endtask

  // One acquisition cycle seen from the chip
  task automatic runEvent(input int unsigned nWords, input logic cutAcq,
                          input logic holdBusy, input logic lastEvent);
    EventPkg::dataWord_t words[$];
    int unsigned         rnd;
    for (int unsigned i = 0; i < nWords; i++) begin
      rnd = $urandom();
      words.push_back(rnd[15:0]);
      chk.addWord(rnd[15:0]);
    end
    chk.closeEvent(holdBusy ? FifoDepth : NoLimit);
    while (!asicCtrl.startAcq) @(negedge Clk);
    outBusy = holdBusy;
    if (lastEvent) begin
      start       = 1'b0; // No further launch
      startEnable = 1'b0;
    end
    if (cutAcq) begin
      waitCycles(5);
      chipSatB = 1'b0; // Chip full mid window
    end
    while (asicCtrl.startAcq) @(negedge Clk);
    chipSatB = 1'b0;
    waitCycles(4);
    chipSatB = 1'b1; // Ready for readout
    while (!asicCtrl.startReadout) @(negedge Clk);
    waitCycles(2);
    foreach (words[i]) begin
      sendWord(words[i]);
    end
    @(negedge Clk);
    transmitOn = 1'b0;
    dout       = 1'b0;
    waitCycles(3);
    endReadout = 1'b1;
    waitCycles(3);
    endReadout = 1'b0;
    while (!onceEnd) @(negedge Clk);
    waitCycles(4);
    outBusy = 1'b0; // Host takes the stalled frame
    while (chk.pendingWords() != 0) @(negedge Clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    seedVal     = $urandom(32'h1ca5_8105);
    start       = 1'b0;
    startEnable = 1'b0;
    acqTime     = 16'd30;
    chipSatB    = 1'b1;
    endReadout  = 1'b0;
    dout        = 1'b0;
    transmitOn  = 1'b0;
    outBusy     = 1'b0;
    @(posedge reset_n);
    waitCycles(10);
    start = 1'b1; // First edge
    runEvent($urandom_range(8, 1), 1'b0, 1'b0, 1'b0);
    start = 1'b0;
    waitCycles(4);
    start = 1'b1; // Fresh edge, short window
    runEvent($urandom_range(8, 1), 1'b1, 1'b0, 1'b0);
    startEnable = 1'b1; // Free running from here
    runEvent($urandom_range(8, 1), 1'b0, 1'b0, 1'b0);
    runEvent($urandom_range(8, 1), 1'b0, 1'b0, 1'b0);
    runEvent($urandom_range(14, 8), 1'b0, 1'b1, 1'b0); // Stall, fits the FIFO
    runEvent(24, 1'b0, 1'b1, 1'b1);                    // Stall past FIFO depth
    waitCycles(10);
    chk.report();
    if (chk.errorCount() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  always @(posedge Clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= CycleLimit) begin
      $display("Timeout: run still busy after %0d clock cycles", CycleLimit);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

//--- sim/DaqChecker.sv
`timescale 1ns/1ps

module DaqChecker #(
  parameter int unsigned PwrRstCycles   = 8,
  parameter int unsigned RstStartCycles = 40,
  parameter int unsigned SroCycles      = 16
) (
  input logic                  Clk,
  input logic                  reset_n,
  input logic [15:0]           acqTime,
  input logic                  chipSatB,
  input logic                  outBusy,
  input DaqCtrlPkg::asicCtrl_t asicCtrl,
  input logic                  onceEnd,
  input EventPkg::dataWord_t   outWord,
  input logic                  outValid,
  input logic                  overflow
);

  // Board reset values of the control pins
  localparam DaqCtrlPkg::asicCtrl_t IdleCtrl = '{resetB: 1'b1, default: 1'b0};

  EventPkg::dataWord_t   sentWords[$];        // Words of the next event, from the ASIC model
  EventPkg::dataWord_t   expQ[$];             // Host words still due
  EventPkg::dataWord_t   expWord;
  logic [7:0]            eventNum     = 8'd0;
  logic                  lossExpected = 1'b0; // Host stall longer than the FIFO
  int unsigned           valueErrors  = 0;
  int unsigned           otherErrors  = 0;
  int unsigned           wordsChecked = 0;
  DaqCtrlPkg::asicCtrl_t prev         = IdleCtrl;
  logic                  prevOnceEnd  = 1'b0;
  logic                  prevOverflow = 1'b0;
  logic                  idleChecked  = 1'b0;
  logic                  gapRun       = 1'b0; // Counting release to startAcq
  logic                  satCut       = 1'b0; // Chip full seen inside the window
  logic                  aExp         = 1'b0; // Expected pwrA and pwrDac
  logic                  dExp         = 1'b0; // Expected pwrD
  logic                  dArm         = 1'b0;
  logic                  rbFall;
  logic                  sroRise;
  logic                  sroFall;
  int unsigned           rbLow        = 0;
  int unsigned           gapCnt       = 0;
  int unsigned           acqCnt       = 0;
  int unsigned           sroCnt       = 0;

  ////////////////////////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////////////////////////

  task automatic valueError(input string name, input int unsigned expVal,
                            input int unsigned actVal);
    $display("error at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, expVal, actVal);
    valueErrors++;
  endtask

  task automatic otherError(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    otherErrors++;
  endtask

  ////////////////////////////////////////////////////////////
  // Reference frame
  ////////////////////////////////////////////////////////////

  // Header, data words in order, trailer with the count
  // Only cap entries survive a host stall, trailer needs its own slot
  function automatic void buildFrame(input logic [7:0] evNum, input int unsigned cap);
    int unsigned kept;
    kept = (sentWords.size() < cap) ? sentWords.size() : cap;
    expQ.push_back({EventPkg::HeaderMark, evNum});
    for (int unsigned i = 0; i < kept; i++) begin
      expQ.push_back(sentWords[i]);
    end
    if (kept + 1 <= cap) begin
      expQ.push_back({EventPkg::TrailerMark, kept[7:0]});
    end
  endfunction

  task automatic addWord(input EventPkg::dataWord_t w);
    sentWords.push_back(w);
  endtask

  task automatic closeEvent(input int unsigned cap);
    if (sentWords.size() >= cap) begin
      lossExpected = 1'b1; // Words or trailer will be dropped
    end
    buildFrame(eventNum, cap);
    eventNum = eventNum + 8'd1;
    sentWords.delete();
  endtask

  function automatic int unsigned pendingWords();
    return expQ.size();
  endfunction

  function automatic int unsigned errorCount();
    return valueErrors + otherErrors;
  endfunction

  task automatic report();
    if (expQ.size() != 0) begin
      otherError($sformatf("%0d expected host words never arrived", expQ.size()));
    end
    if (lossExpected && !overflow) begin
      otherError("overflow was not set although words were lost");
    end
    $display("Checked %0d host words: %0d value errors, %0d other errors",
             wordsChecked, valueErrors, otherErrors);
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor, sampled on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge Clk) begin
    if (reset_n) begin
      if (!idleChecked) begin // First cycle out of reset
        idleChecked = 1'b1;
        if (asicCtrl != IdleCtrl) begin
          valueError("asicCtrl", 32'(IdleCtrl), 32'(asicCtrl));
        end
        if (onceEnd || outValid || overflow) begin
          otherError("onceEnd, outValid or overflow high right after reset");
        end
      end
      // Release gap
      if (gapRun) begin
        gapCnt++;
        if (asicCtrl.startAcq) begin
          gapRun = 1'b0;
          if (gapCnt != RstStartCycles + 1) begin
            valueError("resetB rise to startAcq rise", RstStartCycles + 1, gapCnt);
          end
        end
      end
      if (!asicCtrl.resetB) begin
        rbLow++;
      end else if (!prev.resetB) begin
        if (rbLow != PwrRstCycles + 2) begin
          valueError("resetB low width", PwrRstCycles + 2, rbLow);
        end
        rbLow  = 0;
        gapCnt = 0;
        gapRun = 1'b1;
      end
      // Acquisition window
      if (asicCtrl.startAcq) begin
        acqCnt++;
        if (!chipSatB) begin
          satCut = 1'b1;
        end
      end else if (prev.startAcq) begin
        if (satCut) begin
          if (acqCnt >= 32'(acqTime) + 1) begin
            otherError("chipSatB falling edge did not shorten startAcq");
          end
        end else if (acqCnt != 32'(acqTime) + 1) begin
          valueError("startAcq width", 32'(acqTime) + 1, acqCnt);
        end
        acqCnt = 0;
        satCut = 1'b0;
      end
      if (asicCtrl.startReadout) begin
        sroCnt++;
      end else if (prev.startReadout) begin
        if (sroCnt != SroCycles + 1) begin
          valueError("startReadout width", SroCycles + 1, sroCnt);
        end
        sroCnt = 0;
      end
      if (onceEnd && prevOnceEnd) begin
        otherError("onceEnd stayed high for more than one cycle");
      end
      // Power pulsing windows
      rbFall  = !asicCtrl.resetB && prev.resetB;
      sroRise = asicCtrl.startReadout && !prev.startReadout;
      sroFall = !asicCtrl.startReadout && prev.startReadout;
      if (rbFall) begin
        aExp = 1'b1;
      end else if (sroFall) begin
        aExp = 1'b0;
      end
      if (dArm) begin
        dExp = 1'b1; // One cycle after resetB falls
      end
      if (sroRise) begin
        dExp = 1'b0;
      end
      dArm = rbFall;
      if (asicCtrl.pwrA != aExp) valueError("pwrA", 32'(aExp), 32'(asicCtrl.pwrA));
      if (asicCtrl.pwrDac != aExp) valueError("pwrDac", 32'(aExp), 32'(asicCtrl.pwrDac));
      if (asicCtrl.pwrD != dExp) valueError("pwrD", 32'(dExp), 32'(asicCtrl.pwrD));
      // Host side
      if (outValid && outBusy) begin
        otherError("outValid high while outBusy is high");
      end
      if (outValid) begin
        if (expQ.size() == 0) begin
          otherError($sformatf("host word 0x%h arrived with none expected", outWord));
        end else begin
          expWord = expQ.pop_front();
          wordsChecked++;
          if (outWord != expWord) begin
            valueError("outWord", 32'(expWord), 32'(outWord));
          end
        end
      end
      if (overflow && !prevOverflow && !lossExpected) begin
        valueError("overflow", 0, 1);
      end
      prev         = asicCtrl;
      prevOnceEnd  = onceEnd;
      prevOverflow = overflow;
    end
  end

endmodule

//--- sim/ClkGen.sv
`timescale 1ns/1ps

module ClkGen (
  output logic Clk,
  output logic reset_n
);

  initial begin
    Clk     = 1'b0;
    reset_n = 1'b0;
    repeat (5) @(posedge Clk);
    @(negedge Clk);
    reset_n = 1'b1; // Five cycles, released on a falling edge
  end

  always #2 Clk = ~Clk; // 4 ns period

endmodule

//--- hdl/MicrorocDaq.sv
`timescale 1ns/1ps

module MicrorocDaq #(
  parameter int unsigned PwrRstCycles   = 8,
  parameter int unsigned RstStartCycles = 40,
  parameter int unsigned SroCycles      = 16,
  parameter int unsigned FifoDepth      = 16
) (
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  logic                  startEnable,
  input  logic [15:0]           acqTime,
  input  logic                  chipSatB,    // Active low, async
  input  logic                  endReadout,  // Async
  input  logic                  dout,        // Serial readout data
  input  logic                  transmitOn,
  input  logic                  outBusy,
  output DaqCtrlPkg::asicCtrl_t asicCtrl,
  output logic                  onceEnd,
  output EventPkg::dataWord_t   outWord,
  output logic                  outValid,
  output logic                  overflow
);

  logic                 wrEn;
  EventPkg::fifoEntry_t wrEntry;
  logic                 rdEn;
  EventPkg::fifoEntry_t rdEntry;
  logic                 fifoFull;
  logic                 fifoEmpty;

  ////////////////////////////////////////////////////////////
  // Control and readout chain
  ////////////////////////////////////////////////////////////

  DaqSequencer #(
    .PwrRstCycles  (PwrRstCycles),
    .RstStartCycles(RstStartCycles),
    .SroCycles     (SroCycles)
  ) sequencer (
    .Clk        (Clk),
    .reset_n    (reset_n),
    .start      (start),
    .startEnable(startEnable),
    .chipSatB   (chipSatB),
    .endReadout (endReadout),
    .acqTime    (acqTime),
    .asicCtrl   (asicCtrl),
    .onceEnd    (onceEnd)
  );

  // Producer
  ReadoutDeserializer deser (
    .Clk       (Clk),
    .reset_n   (reset_n),
    .dout      (dout),
    .transmitOn(transmitOn),
    .onceEnd   (onceEnd),
    .fifoFull  (fifoFull),
    .wrEn      (wrEn),
    .wrEntry   (wrEntry),
    .overflow  (overflow)
  );

  EventFifo #(
    .FifoDepth(FifoDepth)
  ) fifo (
    .Clk    (Clk),
    .reset_n(reset_n),
    .wrEn   (wrEn),
    .wrEntry(wrEntry),
    .rdEn   (rdEn),
    .rdEntry(rdEntry),
    .full   (fifoFull),
    .empty  (fifoEmpty)
  );

  // Consumer, host side
  EventFramer framer (
    .Clk     (Clk),
    .reset_n (reset_n),
    .rdEntry (rdEntry),
    .empty   (fifoEmpty),
    .outBusy (outBusy),
    .rdEn    (rdEn),
    .outWord (outWord),
    .outValid(outValid)
  );

endmodule

//--- hdl/EventFramer.sv
`timescale 1ns/1ps

module EventFramer (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  EventPkg::fifoEntry_t rdEntry, // FIFO head
  input  logic                 empty,
  input  logic                 outBusy, // Host back-pressure
  output logic                 rdEn,
  output EventPkg::dataWord_t  outWord,
  output logic                 outValid
);

  EventPkg::frameState_e state;
  logic [7:0]            eventNum; // Wraps after 256 events
  logic                  go;       // Something to send, host ready

  assign go = ~empty & ~outBusy;

  ////////////////////////////////////////////////////////////
  // Output word select
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdEn     = 1'b0;
    outValid = 1'b0;
    outWord  = {EventPkg::HeaderMark, eventNum};
    case (state)
      EventPkg::Body: begin
        rdEn     = go;
        outValid = go;
        if (rdEntry.last) begin
          outWord = {EventPkg::TrailerMark, rdEntry.data[7:0]}; // Count low byte
        end else begin
          outWord = rdEntry.data;
        end
      end
      EventPkg::Trailer: begin
        outValid = 1'b0; // Gap between events
      end
      default: begin
        outValid = go; // Header waits for first entry, no pop
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= EventPkg::Header;
      eventNum <= 8'd0;
    end else begin
      case (state)
        EventPkg::Header: begin
          if (go) begin
            state <= EventPkg::Body;
          end
        end
        EventPkg::Body: begin
          if (go && rdEntry.last) begin
            state <= EventPkg::Trailer;
          end
        end
        EventPkg::Trailer: begin
          eventNum <= eventNum + 8'd1; // Next event number
          state    <= EventPkg::Header;
        end
        default: begin
          state <= EventPkg::Header;
        end
      endcase
    end
  end

endmodule

//--- hdl/EventFifo.sv
`timescale 1ns/1ps

module EventFifo #(
  parameter int unsigned FifoDepth = 16 // Power of two
) (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 wrEn,
  input  EventPkg::fifoEntry_t wrEntry,
  input  logic                 rdEn,
  output EventPkg::fifoEntry_t rdEntry, // Head entry, no read latency
  output logic                 full,
  output logic                 empty
);

  localparam int unsigned AddrW = $clog2(FifoDepth);

  EventPkg::fifoEntry_t mem [FifoDepth];
  logic [AddrW:0]       wrPtr; // Top bit is the wrap flag
  logic [AddrW:0]       rdPtr;
  logic                 doWrite;
  logic                 doRead;

  assign doWrite = wrEn & ~full;
  assign doRead  = rdEn & ~empty;

  // Same index, different lap means full
  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[AddrW] != rdPtr[AddrW]) &&
                 (wrPtr[AddrW-1:0] == rdPtr[AddrW-1:0]);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + (AddrW+1)'(1);
      end
      if (doRead) begin
        rdPtr <= rdPtr + (AddrW+1)'(1);
      end
    end
  end

  // Storage
  always_ff @(posedge Clk) begin
    if (doWrite) begin
      mem[wrPtr[AddrW-1:0]] <= wrEntry;
    end
  end

  assign rdEntry = mem[rdPtr[AddrW-1:0]];

endmodule

//--- hdl/ReadoutDeserializer.sv
`timescale 1ns/1ps

module ReadoutDeserializer (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 dout,       // Serial data, MSB first
  input  logic                 transmitOn, // Bits valid while high
  input  logic                 onceEnd,    // Event finished
  input  logic                 fifoFull,
  output logic                 wrEn,
  output EventPkg::fifoEntry_t wrEntry,
  output logic                 overflow    // Sticky word loss flag
);

  EventPkg::dataWord_t shiftReg;
  EventPkg::dataWord_t wordCnt;  // Words written this event
  logic [3:0]          bitCnt;
  logic                pending;  // wrEntry holds an unwritten entry
  logic                wordDone; // Sixteenth bit arriving now
  logic                dataPush; // Data word goes into the FIFO

  assign wordDone = transmitOn & (bitCnt == 4'd15);
  assign wrEn     = pending & ~fifoFull; // Drop instead of stall
  assign dataPush = wrEn & ~wrEntry.last;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      bitCnt   <= 4'd0;
      pending  <= 1'b0;
      wordCnt  <= '0;
      overflow <= 1'b0;
    end else begin
      // Partial word thrown away when the stream stops
      if (transmitOn && !onceEnd) begin
        bitCnt <= bitCnt + 4'd1;
      end else begin
        bitCnt <= 4'd0;
      end
      pending <= wordDone | onceEnd;
      if (onceEnd) begin
        wordCnt <= '0;
      end else if (dataPush) begin
        wordCnt <= wordCnt + 16'd1;
      end
      if (pending && fifoFull) begin
        overflow <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (transmitOn) begin
      shiftReg <= {shiftReg[14:0], dout};
    end
    if (onceEnd) begin
      wrEntry.last <= 1'b1;
      wrEntry.data <= wordCnt + 16'(dataPush); // Count the word leaving now
    end else if (wordDone) begin
      wrEntry.last <= 1'b0;
      wrEntry.data <= {shiftReg[14:0], dout};
    end
  end

endmodule

//--- hdl/DaqSequencer.sv
`timescale 1ns/1ps

module DaqSequencer #(
  parameter int unsigned PwrRstCycles   = 8,  // Reset hold after power on
  parameter int unsigned RstStartCycles = 40, // Reset release to acquisition
  parameter int unsigned SroCycles      = 16  // Readout start pulse length
) (
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  start,       // Run level from host
  input  logic                  startEnable, // Free-running mode
  input  logic                  chipSatB,    // Chip full, active low, async
  input  logic                  endReadout,  // Readout done, async
  input  logic [15:0]           acqTime,     // Acquisition window length
  output DaqCtrlPkg::asicCtrl_t asicCtrl,
  output logic                  onceEnd      // One cycle per finished cycle
);

  ////////////////////////////////////////////////////////////
  // Synchronizers and edge detection
  ////////////////////////////////////////////////////////////

  logic [2:0] startSync; // Bit 0 samples the pin
  logic [2:0] satSync;
  logic [2:0] endSync;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      startSync <= 3'b000;
      satSync   <= 3'b111; // Chip not full
      endSync   <= 3'b000;
    end else begin
      startSync <= {startSync[1:0], start};
      satSync   <= {satSync[1:0], chipSatB};
      endSync   <= {endSync[1:0], endReadout};
    end
  end

  logic startRise; // Host start edge
  logic chipFull;  // chipSatB falling, chip memory full
  logic readStart; // chipSatB rising, chip ready for readout
  logic readEnd;   // endReadout falling

  assign startRise = startSync[1] & ~startSync[2];
  assign chipFull  = ~satSync[1] & satSync[2];
  assign readStart = satSync[1] & ~satSync[2];
  assign readEnd   = ~endSync[1] & endSync[2];

  ////////////////////////////////////////////////////////////
  // Acquisition FSM
  ////////////////////////////////////////////////////////////

  DaqCtrlPkg::daqState_e state;
  logic [15:0] delayCnt;     // Shared by all timed states
  logic        resetB;
  logic        startAcq;
  logic        startReadout;
  logic        launch;

  // Host level up and either a fresh edge or auto restart
  assign launch = startSync[1] & (startRise | startEnable);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state        <= DaqCtrlPkg::Idle;
      delayCnt     <= 16'd0;
      resetB       <= 1'b1; // Chip runs free after board reset
      startAcq     <= 1'b0;
      startReadout <= 1'b0;
      onceEnd      <= 1'b0;
    end else begin
      case (state)
        DaqCtrlPkg::Idle: begin
          if (launch) begin
            resetB <= 1'b0;
            state  <= DaqCtrlPkg::ChipReset;
          end
        end
        DaqCtrlPkg::ChipReset: begin
          state <= DaqCtrlPkg::PowerOn;
        end
        DaqCtrlPkg::PowerOn: begin
          if (delayCnt < 16'(PwrRstCycles)) begin
            delayCnt <= delayCnt + 16'd1;
          end else begin
            delayCnt <= 16'd0;
            resetB   <= 1'b1;
            state    <= DaqCtrlPkg::Release;
          end
        end
        DaqCtrlPkg::Release: begin
          if (delayCnt < 16'(RstStartCycles)) begin
            delayCnt <= delayCnt + 16'd1;
          end else begin
            delayCnt <= 16'd0;
            startAcq <= 1'b1;
            state    <= DaqCtrlPkg::Acquisition;
          end
        end
        DaqCtrlPkg::Acquisition: begin
          // Chip full cuts the window short
          if (chipFull || delayCnt >= acqTime) begin
            delayCnt <= 16'd0;
            startAcq <= 1'b0;
            state    <= DaqCtrlPkg::WaitFull;
          end else begin
            delayCnt <= delayCnt + 16'd1;
          end
        end
        DaqCtrlPkg::WaitFull: begin
          if (readStart) begin // No timeout here
            startReadout <= 1'b1;
            state        <= DaqCtrlPkg::StartReadout;
          end
        end
        DaqCtrlPkg::StartReadout: begin
          if (delayCnt < 16'(SroCycles)) begin
            delayCnt <= delayCnt + 16'd1;
          end else begin
            delayCnt     <= 16'd0;
            startReadout <= 1'b0;
            state        <= DaqCtrlPkg::WaitRead;
          end
        end
        DaqCtrlPkg::WaitRead: begin
          if (readEnd) begin
            onceEnd <= 1'b1;
            state   <= DaqCtrlPkg::EndReadout;
          end
        end
        DaqCtrlPkg::EndReadout: begin
          onceEnd <= 1'b0;
          state   <= DaqCtrlPkg::Idle;
        end
        default: begin
          state <= DaqCtrlPkg::Idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Power pulsing decode
  ////////////////////////////////////////////////////////////

  logic pwrD;
  logic pwrA;

  always_comb begin
    pwrD = 1'b0;
    pwrA = 1'b0;
    case (state)
      DaqCtrlPkg::ChipReset:    pwrA = 1'b1; // Analog first
      DaqCtrlPkg::PowerOn,
      DaqCtrlPkg::Release,
      DaqCtrlPkg::Acquisition,
      DaqCtrlPkg::WaitFull: begin
        pwrD = 1'b1;
        pwrA = 1'b1;
      end
      DaqCtrlPkg::StartReadout: pwrA = 1'b1; // Digital off for readout
      default: begin
        pwrD = 1'b0;
        pwrA = 1'b0;
      end
    endcase
  end

  always_comb begin
    asicCtrl.resetB       = resetB;
    asicCtrl.startAcq     = startAcq;
    asicCtrl.startReadout = startReadout;
    asicCtrl.pwrA         = pwrA;
    asicCtrl.pwrD         = pwrD;
    asicCtrl.pwrDac       = pwrA; // DAC follows analog supply
  end

endmodule

//--- hdl/EventPkg.sv
package EventPkg;

  ////////////////////////////////////////////////////////////
  // Readout words and buffer entries
  ////////////////////////////////////////////////////////////

  typedef logic [15:0] dataWord_t; // One deserialized readout word

  // Buffer entry, data holds the event word count when last is set
  typedef struct packed {
    logic      last; // End of event marker
    dataWord_t data; // Readout word or word count
  } fifoEntry_t;

  ////////////////////////////////////////////////////////////
  // Host framing
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    Header  = 2'd0, // Header word pending
    Body    = 2'd1, // Forwarding data words
    Trailer = 2'd2  // Event closed
  } frameState_e;

  // Upper byte marks of header and trailer words
  localparam logic [7:0] HeaderMark  = 8'hA5;
  localparam logic [7:0] TrailerMark = 8'h5A;

endpackage

//--- hdl/DaqCtrlPkg.sv
package DaqCtrlPkg;

  ////////////////////////////////////////////////////////////
  // Acquisition sequencer states
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    Idle         = 4'd0, // Waiting for a launch
    ChipReset    = 4'd1, // resetB just pulled low
    PowerOn      = 4'd2, // Digital supply up, reset still held
    Release      = 4'd3, // Reset released, settling
    Acquisition  = 4'd4, // startAcq window
    WaitFull     = 4'd5, // Wait for chip to finish
    StartReadout = 4'd6, // startReadout pulse
    WaitRead     = 4'd7, // Readout in progress
    EndReadout   = 4'd8  // onceEnd cycle
  } daqState_e;

  ////////////////////////////////////////////////////////////
  // ASIC control pins
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic resetB;       // Digital part reset, active low
    logic startAcq;     // Acquisition window
    logic startReadout; // Digital RAM readout start
    logic pwrA;         // Analog power pulsing
    logic pwrD;         // Digital power pulsing
    logic pwrDac;       // DAC power pulsing
  } asicCtrl_t;

endpackage
